//--- rtl/alu_pkg.sv
// alu opcode enum and default datapath width

package alu_pkg;

    // default datapath width, top level passes its own WIDTH down
    localparam int ALU_WIDTH_DEFAULT = 8;

    // opcode encoding, gaps are reserved
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,      // arg0 passed through
        OP_ADD = 4'h1,      // arg0 plus arg1
        OP_SUB = 4'h2,      // arg0 minus arg1
        OP_MUL = 4'h3,      // low WIDTH bits of product
        OP_AND = 4'h4,      // bitwise and
        OP_OR  = 4'h5,      // bitwise or
        OP_XOR = 4'h6,      // bitwise xor
        OP_ROL = 4'h8       // arg0 rotated left by one, arg1 unused
    } alu_op_e;

endpackage

//--- rtl/bist_pkg.sv
// sequencer state enum, script length and requester index enum

package bist_pkg;

    // steps in the fixed self test script
    localparam int SCRIPT_LEN = 9;

    // step machine of the script sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,   // waiting for i_run
        SEQ_ISSUE = 2'd1,   // request held until granted
        SEQ_WAIT  = 2'd2,   // waiting for the result pulse
        SEQ_DONE  = 2'd3    // script finished, waiting for i_run low
    } seq_state_e;

    // who owns an alu slot
    typedef enum logic {
        REQ_HOST = 1'b0,    // external host port
        REQ_BIST = 1'b1     // script sequencer
    } requester_e;

endpackage

//--- rtl/alu.sv
// registered alu, one opcode per cycle, one cycle result latency

`timescale 1ns/1ps

module alu
    import alu_pkg::*;
#(
    parameter int WIDTH = ALU_WIDTH_DEFAULT                 // datapath width
) (
    input  logic             i_clk,                         // system clock
    input  logic             i_rst_n,                       // async reset, active low
    input  logic             i_valid,                       // operation presented this cycle
    input  alu_op_e          i_op,                          // opcode
    input  logic [WIDTH-1:0] i_arg0,                        // first operand
    input  logic [WIDTH-1:0] i_arg1,                        // second operand
    output logic [WIDTH-1:0] o_data                         // registered result
);

    logic [WIDTH-1:0] result;                               // combinational result
    logic [WIDTH-1:0] r_data;                               // result register

    always_comb begin
        case (i_op)
            OP_NOP: begin
                result = i_arg0;                            // pass through
            end
            OP_ADD: begin
                result = i_arg0 + i_arg1;                   // carry dropped
            end
            OP_SUB: begin
                result = i_arg0 - i_arg1;                   // wraps on borrow
            end
            OP_MUL: begin
                result = i_arg0 * i_arg1;                   // low half of product only
            end
            OP_AND: begin
                result = i_arg0 & i_arg1;
            end
            OP_OR: begin
                result = i_arg0 | i_arg1;
            end
            OP_XOR: begin
                result = i_arg0 ^ i_arg1;
            end
            OP_ROL: begin
                result = {i_arg0[WIDTH-2:0], i_arg0[WIDTH-1]};  // msb wraps to bit 0
            end
            default: begin
                result = '0;                                // reserved codes
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_data <= '0;
        end else if (i_valid) begin
            r_data <= result;                               // hold old value otherwise
        end
    end

    assign o_data = r_data;

    // requesters only ever issue defined opcodes
    a_op_defined: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> i_op inside {OP_NOP, OP_ADD, OP_SUB, OP_MUL,
                                 OP_AND, OP_OR, OP_XOR, OP_ROL})
        else $error("alu received undefined opcode %0h", i_op);

endmodule

//--- rtl/alu_arbiter.sv
// two way round robin arbiter for the alu, with result routing back to the owner

`timescale 1ns/1ps

module alu_arbiter
    import alu_pkg::*, bist_pkg::*;
#(
    parameter int WIDTH = ALU_WIDTH_DEFAULT                 // datapath width
) (
    input  logic             i_clk,                         // system clock
    input  logic             i_rst_n,                       // async reset, active low

    input  logic             i_host_req,                    // host request level
    input  alu_op_e          i_host_op,                     // host opcode
    input  logic [WIDTH-1:0] i_host_arg0,                   // host operand 0
    input  logic [WIDTH-1:0] i_host_arg1,                   // host operand 1
    output logic             o_host_gnt,                    // host grant pulse
    output logic             o_host_valid,                  // host result pulse
    output logic [WIDTH-1:0] o_host_data,                   // host result

    input  logic             i_bist_req,                    // sequencer request level
    input  alu_op_e          i_bist_op,                     // sequencer opcode
    input  logic [WIDTH-1:0] i_bist_arg0,                   // sequencer operand 0
    input  logic [WIDTH-1:0] i_bist_arg1,                   // sequencer operand 1
    output logic             o_bist_gnt,                    // sequencer grant pulse
    output logic             o_bist_valid,                  // sequencer result pulse
    output logic [WIDTH-1:0] o_bist_data,                   // sequencer result

    output logic             o_alu_valid,                   // operation to alu
    output alu_op_e          o_alu_op,                      // opcode to alu
    output logic [WIDTH-1:0] o_alu_arg0,                    // operand 0 to alu
    output logic [WIDTH-1:0] o_alu_arg1,                    // operand 1 to alu
    input  logic [WIDTH-1:0] i_alu_data                     // registered alu result
);

    requester_e r_owner;        // last winner, doubles as tag of the result in flight
    logic       r_busy;         // alu result lands this cycle
    logic       host_win;       // host takes the alu this cycle
    logic       bist_win;       // sequencer takes the alu this cycle

    // alone wins, on contention the one that lost last time wins
    assign host_win = i_host_req && (!i_bist_req || r_owner == REQ_BIST);
    assign bist_win = i_bist_req && (!i_host_req || r_owner == REQ_HOST);

    assign o_host_gnt = host_win;
    assign o_bist_gnt = bist_win;

    assign o_alu_valid = host_win || bist_win;
    assign o_alu_op    = bist_win ? i_bist_op   : i_host_op;    // host is default path
    assign o_alu_arg0  = bist_win ? i_bist_arg0 : i_host_arg0;
    assign o_alu_arg1  = bist_win ? i_bist_arg1 : i_host_arg1;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_owner <= REQ_BIST;                            // host wins first contention
            r_busy  <= 1'b0;
        end else begin
            r_busy <= o_alu_valid;                          // tracks the alu stage
            if (o_alu_valid) begin
                r_owner <= bist_win ? REQ_BIST : REQ_HOST;
            end
        end
    end

    // result pulse only on the side that issued it
    assign o_host_valid = r_busy && (r_owner == REQ_HOST);
    assign o_bist_valid = r_busy && (r_owner == REQ_BIST);
    assign o_host_data  = i_alu_data;
    assign o_bist_data  = i_alu_data;

    a_one_grant: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_host_gnt && o_bist_gnt))
        else $error("arbiter granted host and sequencer together");

    // a waiting request never loses twice in a row
    a_host_fair: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_host_req && !o_host_gnt |=> !i_host_req || o_host_gnt)
        else $error("host request starved for two cycles");

    a_bist_fair: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_bist_req && !o_bist_gnt |=> !i_bist_req || o_bist_gnt)
        else $error("sequencer request starved for two cycles");

endmodule

//--- rtl/bist_sequencer.sv
// fixed script memory, step state machine, result compare and sticky pass flag

`timescale 1ns/1ps

module bist_sequencer
    import alu_pkg::*, bist_pkg::*;
#(
    parameter int WIDTH = ALU_WIDTH_DEFAULT                 // datapath width, 8 or more
) (
    input  logic             i_clk,                         // system clock
    input  logic             i_rst_n,                       // async reset, active low
    input  logic             i_run,                         // hold high to run the test
    output logic             o_running,                     // test in progress
    output logic             o_passed,                      // valid once o_running falls

    output logic             o_req,                         // request level to arbiter
    output alu_op_e          o_op,                          // script opcode
    output logic [WIDTH-1:0] o_arg0,                        // script operand 0
    output logic [WIDTH-1:0] o_arg1,                        // script operand 1
    input  logic             i_gnt,                         // grant pulse
    input  logic             i_valid,                       // result pulse
    input  logic [WIDTH-1:0] i_data                         // alu result
);

    localparam int STEP_W = $clog2(SCRIPT_LEN);

    // script operands are 8 bit wide
    if (WIDTH < 8) begin : g_width_check
        $error("bist_sequencer needs WIDTH of at least 8, got %0d", WIDTH);
    end

    seq_state_e        r_state;                             // step machine
    logic [STEP_W-1:0] r_step;                              // current script step
    logic              r_passed;                            // sticky pass flag
    alu_op_e           step_op;                             // script opcode
    logic [7:0]        step_arg0;                           // script operand 0
    logic [7:0]        step_arg1;                           // script operand 1
    logic [7:0]        step_exp;                            // expected result
    logic              last_step;                           // final entry of the script

    // script rom, one row per step
    always_comb begin
        step_op   = OP_NOP;
        step_arg0 = 8'h00;
        step_arg1 = 8'h00;
        step_exp  = 8'h00;
        case (r_step)
            0: begin
                step_op   = OP_ADD;                         // 5 + 8
                step_arg0 = 8'd5;
                step_arg1 = 8'd8;
                step_exp  = 8'd13;
            end
            1: begin
                step_op   = OP_SUB;                         // 21 - 8
                step_arg0 = 8'd21;
                step_arg1 = 8'd8;
                step_exp  = 8'd13;
            end
            2: begin
                step_op   = OP_AND;
                step_arg0 = 8'hCC;
                step_arg1 = 8'hAA;
                step_exp  = 8'h88;
            end
            3: begin
                step_op   = OP_OR;
                step_arg0 = 8'hCC;
                step_arg1 = 8'hAA;
                step_exp  = 8'hEE;
            end
            4: begin
                step_op   = OP_XOR;
                step_arg0 = 8'hCA;
                step_arg1 = 8'hAC;
                step_exp  = 8'h66;
            end
            5: begin
                step_op   = OP_ROL;                         // msb clear, so any WIDTH works
                step_arg0 = 8'h4D;
                step_exp  = 8'h9A;
            end
            6: begin
                step_op   = OP_MUL;                         // 8 * 13
                step_arg0 = 8'd8;
                step_arg1 = 8'd13;
                step_exp  = 8'd104;
            end
            7: begin
                step_op   = OP_NOP;
                step_arg0 = 8'h7F;
                step_exp  = 8'h7F;
            end
            8: begin
                step_op   = OP_SUB;                         // equal operands give zero
                step_arg0 = 8'd13;
                step_arg1 = 8'd13;
                step_exp  = 8'd0;
            end
            default: begin
                step_op   = OP_NOP;                         // unreachable rows
            end
        endcase
    end

    assign last_step = (r_step == STEP_W'(SCRIPT_LEN - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state  <= SEQ_IDLE;
            r_step   <= '0;
            r_passed <= 1'b1;
        end else begin
            case (r_state)
                SEQ_IDLE: begin
                    if (i_run) begin
                        r_state  <= SEQ_ISSUE;
                        r_step   <= '0;
                        r_passed <= 1'b1;                   // fresh run starts clean
                    end
                end
                SEQ_ISSUE: begin
                    if (!i_run) begin
                        r_state <= SEQ_IDLE;                // request withdrawn
                    end else if (i_gnt) begin
                        r_state <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    if (!i_run) begin
                        r_state <= SEQ_IDLE;                // abort, result pulse dropped
                    end else if (i_valid) begin
                        if (i_data != WIDTH'(step_exp)) begin
                            r_passed <= 1'b0;               // sticky until next run
                        end
                        if (last_step) begin
                            r_state <= SEQ_DONE;
                        end else begin
                            r_step  <= r_step + 1'b1;
                            r_state <= SEQ_ISSUE;
                        end
                    end
                end
                SEQ_DONE: begin
                    if (!i_run) begin
                        r_state <= SEQ_IDLE;
                    end
                end
                default: begin
                    r_state <= SEQ_IDLE;
                end
            endcase
        end
    end

    assign o_running = i_run && (r_state != SEQ_DONE);
    assign o_passed  = r_passed;
    assign o_req     = i_run && (r_state == SEQ_ISSUE);   // no grant once aborted
    assign o_op      = step_op;
    assign o_arg0    = WIDTH'(step_arg0);                   // zero extended
    assign o_arg1    = WIDTH'(step_arg1);

    // arbiter returns a result only for a request this machine was granted
    a_valid_in_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> r_state == SEQ_WAIT)
        else $error("sequencer got a result pulse outside the wait state");

endmodule

//--- rtl/alu_bist_top.sv
// self test top level joining sequencer, arbiter and alu, with host and test ports

`timescale 1ns/1ps

module alu_bist_top
    import alu_pkg::*;
#(
    parameter int WIDTH = ALU_WIDTH_DEFAULT                 // datapath width, 8 or more
) (
    input  logic             i_clk,                         // system clock
    input  logic             i_rst_n,                       // async reset, active low
    input  logic             i_run,                         // hold high to run the test
    output logic             o_running,                     // test in progress
    output logic             o_passed,                      // test result

    input  logic             i_host_req,                    // host request level
    input  alu_op_e          i_host_op,                     // host opcode
    input  logic [WIDTH-1:0] i_host_arg0,                   // host operand 0
    input  logic [WIDTH-1:0] i_host_arg1,                   // host operand 1
    output logic             o_host_gnt,                    // host grant pulse
    output logic             o_host_valid,                  // host result pulse
    output logic [WIDTH-1:0] o_host_data                    // host result
);

    logic             bist_req;                             // sequencer side of arbiter
    alu_op_e          bist_op;
    logic [WIDTH-1:0] bist_arg0;
    logic [WIDTH-1:0] bist_arg1;
    logic             bist_gnt;
    logic             bist_valid;
    logic [WIDTH-1:0] bist_data;

    logic             alu_valid;                            // arbiter to alu
    alu_op_e          alu_op;
    logic [WIDTH-1:0] alu_arg0;
    logic [WIDTH-1:0] alu_arg1;
    logic [WIDTH-1:0] alu_data;

    bist_sequencer #(
        .WIDTH      (WIDTH)
    ) i_bist_sequencer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_run      (i_run),
        .o_running  (o_running),
        .o_passed   (o_passed),
        .o_req      (bist_req),
        .o_op       (bist_op),
        .o_arg0     (bist_arg0),
        .o_arg1     (bist_arg1),
        .i_gnt      (bist_gnt),
        .i_valid    (bist_valid),
        .i_data     (bist_data)
    );

    alu_arbiter #(
        .WIDTH        (WIDTH)
    ) i_alu_arbiter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_host_req   (i_host_req),
        .i_host_op    (i_host_op),
        .i_host_arg0  (i_host_arg0),
        .i_host_arg1  (i_host_arg1),
        .o_host_gnt   (o_host_gnt),
        .o_host_valid (o_host_valid),
        .o_host_data  (o_host_data),
        .i_bist_req   (bist_req),
        .i_bist_op    (bist_op),
        .i_bist_arg0  (bist_arg0),
        .i_bist_arg1  (bist_arg1),
        .o_bist_gnt   (bist_gnt),
        .o_bist_valid (bist_valid),
        .o_bist_data  (bist_data),
        .o_alu_valid  (alu_valid),
        .o_alu_op     (alu_op),
        .o_alu_arg0   (alu_arg0),
        .o_alu_arg1   (alu_arg1),
        .i_alu_data   (alu_data)
    );

    alu #(
        .WIDTH   (WIDTH)
    ) i_alu (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (alu_valid),
        .i_op    (alu_op),
        .i_arg0  (alu_arg0),
        .i_arg1  (alu_arg1),
        .o_data  (alu_data)
    );

endmodule

//--- tests/alu_bist_tb.sv
// clock, reset, dut instance, host traffic, test runs, reference model and checks

`timescale 1ns/1ps

module alu_bist_tb
    import alu_pkg::*, bist_pkg::*;
;

    localparam int W           = ALU_WIDTH_DEFAULT;         // dut runs at default width
    localparam int GNT_TIMEOUT = 4;                         // cycles before a grant is overdue
    localparam int RUN_TIMEOUT = 400;                       // cycles for a whole script

    logic         i_clk;
    logic         i_rst_n;
    logic         i_run;
    logic         o_running;
    logic         o_passed;
    logic         i_host_req;
    alu_op_e      i_host_op;
    logic [W-1:0] i_host_arg0;
    logic [W-1:0] i_host_arg1;
    logic         o_host_gnt;
    logic         o_host_valid;
    logic [W-1:0] o_host_data;

    logic         gnt_seen;                                 // host grant taken at last edge
    logic [W-1:0] exp_q [$];                                // host results in flight
    logic [W-1:0] exp_head;                                 // oldest expected host result
    alu_op_e      op_list [8] = '{OP_NOP, OP_ADD, OP_SUB, OP_MUL,
                                  OP_AND, OP_OR, OP_XOR, OP_ROL};

    alu_bist_top i_alu_bist_top (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_run        (i_run),
        .o_running    (o_running),
        .o_passed     (o_passed),
        .i_host_req   (i_host_req),
        .i_host_op    (i_host_op),
        .i_host_arg0  (i_host_arg0),
        .i_host_arg1  (i_host_arg1),
        .o_host_gnt   (o_host_gnt),
        .o_host_valid (o_host_valid),
        .o_host_data  (o_host_data)
    );

    always #4 i_clk = ~i_clk;                               // 8 ns period

    // reference model built from the opcode rules
    function automatic logic [W-1:0] alu_model(input alu_op_e op,
                                               input logic [W-1:0] a,
                                               input logic [W-1:0] b);
        logic [2*W-1:0] prod;
        prod = a * b;                                       // full product, low half kept
        case (op)
            OP_NOP:  return a;
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_MUL:  return prod[W-1:0];
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_ROL:  return (a << 1) | (a >> (W - 1));      // b ignored
            default: return '0;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
            else report_failure($sformatf("MISMATCH at %0t: %s expected %b got %b",
                                          $time, name, exp, got));
    endtask

    // grant as seen at the rising edge, read back on the falling edge
    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            gnt_seen <= 1'b0;
        end else begin
            gnt_seen <= o_host_gnt;
        end
    end

    // one entry per host grant, retired by the matching result pulse
    always @(posedge i_clk) begin
        if (o_host_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        if (o_host_gnt) begin
            exp_q.push_back(alu_model(i_host_op, i_host_arg0, i_host_arg1));
        end
        exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    a_gnt_then_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_host_gnt |=> o_host_valid)
        else report_failure("host grant was not followed by a host result pulse");

    a_valid_needs_gnt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_host_valid |-> $past(o_host_gnt))
        else report_failure("host result pulse arrived without a host grant");

    a_host_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_host_valid |-> o_host_data == exp_head)
        else report_failure($sformatf("MISMATCH at %0t: o_host_data expected %0h got %0h",
                                      $time, $sampled(exp_head), $sampled(o_host_data)));

    // waiting host request loses at most once
    a_host_fair: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_host_req && !o_host_gnt |=> o_host_gnt)
        else report_failure("host request was not granted within two cycles");

    a_passed_at_end: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(o_running) |-> o_passed)
        else report_failure($sformatf("MISMATCH at %0t: o_passed expected 1 got %b",
                                      $time, $sampled(o_passed)));

    a_stop_on_run_low: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_run |-> !o_running)
        else report_failure("o_running stayed high with i_run low");

    // called on a falling edge, returns on the falling edge after the grant
    task automatic host_issue(input alu_op_e op, input logic [W-1:0] a0,
                              input logic [W-1:0] a1);
        int waited;
        waited      = 0;
        i_host_req  = 1'b1;
        i_host_op   = op;
        i_host_arg0 = a0;
        i_host_arg1 = a1;
        @(negedge i_clk);
        while (!gnt_seen) begin
            waited++;
            if (waited > GNT_TIMEOUT) begin
                report_failure("host request was never granted");
            end
            @(negedge i_clk);
        end
        i_host_req = 1'b0;                                  // next op may follow at once
    endtask

    task automatic host_burst(input int count);
        int gap;
        for (int n = 0; n < count; n++) begin
            host_issue(op_list[$urandom_range(7, 0)], W'($urandom), W'($urandom));
            gap = $urandom_range(2, 0);
            repeat (gap) @(negedge i_clk);                  // zero gap gives back to back
        end
    endtask

    task automatic wait_running(input logic level, input int limit, input string what);
        int cnt;
        cnt = 0;
        @(negedge i_clk);
        while (o_running !== level) begin
            cnt++;
            if (cnt > limit) begin
                report_failure(what);
            end
            @(negedge i_clk);
        end
    endtask

    task automatic run_test();
        i_run = 1'b1;
        wait_running(1'b1, 4, "o_running did not rise after i_run went high");
        wait_running(1'b0, RUN_TIMEOUT, "test run did not finish in time");
        i_run = 1'b0;                                       // back to idle before next run
        repeat (2) @(negedge i_clk);
    endtask

    initial begin
        void'($urandom(32'hc9ea));
        i_clk       = 1'b0;
        i_rst_n     = 1'b0;
        i_run       = 1'b0;
        i_host_req  = 1'b0;
        i_host_op   = OP_NOP;
        i_host_arg0 = '0;
        i_host_arg1 = '0;

        repeat (3) @(negedge i_clk);
        check_bit("o_running", o_running, 1'b0);            // values held by reset
        check_bit("o_passed", o_passed, 1'b1);
        check_bit("o_host_gnt", o_host_gnt, 1'b0);
        check_bit("o_host_valid", o_host_valid, 1'b0);
        i_rst_n = 1'b1;
        @(negedge i_clk);

        host_burst(24);                                     // host alone on the alu
        repeat (2) @(negedge i_clk);

        run_test();                                         // quiet self test

        fork                                                // self test under host load
            run_test();
            host_burst(40);
        join
        repeat (2) @(negedge i_clk);

        i_run = 1'b1;                                       // abort mid script
        wait_running(1'b1, 4, "o_running did not rise before the abort");
        repeat (7) @(negedge i_clk);
        check_bit("o_running", o_running, 1'b1);            // script still in progress
        i_run = 1'b0;
        wait_running(1'b0, 0, "o_running stayed high after the abort");
        repeat (2) @(negedge i_clk);
        run_test();                                         // restart after abort

        repeat (3) @(negedge i_clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- alu_bist.f
rtl/alu_pkg.sv
rtl/bist_pkg.sv
rtl/alu.sv
rtl/alu_arbiter.sv
rtl/bist_sequencer.sv
rtl/alu_bist_top.sv
tests/alu_bist_tb.sv
